//--- build.sh
#!/usr/bin/env bash
# build the fifoStream testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module FifoStreamTb \
	-Mdir obj_dir \
	-f fifoStream.f

./obj_dir/VFifoStreamTb

//--- fifoStream.f
+incdir+source
source/fifoStreamPkg.sv
source/SdpBram.sv
source/SyncFifoController.sv
source/FifoLevelMonitor.sv
source/FifoCsr.sv
source/FifoStreamTop.sv
testbench/FifoStream_sva.sv
testbench/FifoStreamTb.sv

//--- source/FifoCsr.sv
`timescale 1ns/1ps
`include "fifoStream_config.svh"

module FifoCsr
(
	input  logic                       iCLK,
	input  logic                       inARST,
	input  fifoStreamPkg::axiLiteReq_t axiReq,
	input  fifoStreamPkg::fsStatus_t   status,
	input  fifoStreamPkg::fsMonitor_t  mon,
	output fifoStreamPkg::axiLiteRsp_t axiRsp,
	output fifoStreamPkg::fsCtrl_t     ctrl,
	output logic                       dropClear
);

	// watermark after reset, 16 below the usable capacity
	localparam fifoStreamPkg::fsLevel_t lpWmarkReset =
		fifoStreamPkg::fsLevel_t'(`FS_DEPTH - 1 - 16);

	fifoStreamPkg::csrState_t wrState;
	fifoStreamPkg::csrState_t rdState;
	fifoStreamPkg::axiAddr_t  awAddr;
	fifoStreamPkg::axiData_t  wData;
	fifoStreamPkg::axiData_t  rdWord;
	fifoStreamPkg::axiData_t  rData;
	logic                     awHeld;
	logic                     wHeld;
	logic                     wrCommit;
	logic                     arAccept;

	//----------------------------------------
	// channel handshakes
	//----------------------------------------
	// address and data each taken once, in either order
	assign axiRsp.awready = (wrState == fifoStreamPkg::CSR_IDLE) && !awHeld;
	assign axiRsp.wready  = (wrState == fifoStreamPkg::CSR_IDLE) && !wHeld;
	assign axiRsp.bvalid  = (wrState == fifoStreamPkg::CSR_RESP);
	assign axiRsp.arready = (rdState == fifoStreamPkg::CSR_IDLE);
	assign axiRsp.rvalid  = (rdState == fifoStreamPkg::CSR_RESP);
	assign axiRsp.rdata   = rData;

	// register write once both halves are held
	assign wrCommit = (wrState == fifoStreamPkg::CSR_IDLE) && awHeld && wHeld;
	assign arAccept = axiReq.arvalid && axiRsp.arready;

	//----------------------------------------
	// write machine
	//----------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wrState <= fifoStreamPkg::CSR_IDLE;
			awHeld  <= 1'b0;
			wHeld   <= 1'b0;
		end
		else
		begin
			if (axiReq.awvalid && axiRsp.awready)
				awHeld <= 1'b1;
			if (axiReq.wvalid && axiRsp.wready)
				wHeld <= 1'b1;
			if (wrCommit)
			begin
				awHeld  <= 1'b0;
				wHeld   <= 1'b0;
				wrState <= fifoStreamPkg::CSR_RESP;
			end
			else if (axiRsp.bvalid && axiReq.bready)
			begin
				wrState <= fifoStreamPkg::CSR_IDLE;
			end
		end
	end

	// held address and data
	always_ff @(posedge iCLK)
	begin
		if (axiReq.awvalid && axiRsp.awready)
			awAddr <= axiReq.awaddr;
		if (axiReq.wvalid && axiRsp.wready)
			wData <= axiReq.wdata;
	end

	//----------------------------------------
	// register file
	//----------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			ctrl.wrEnable  <= 1'b1;
			ctrl.flush     <= 1'b0;
			ctrl.watermark <= lpWmarkReset;
			dropClear      <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			ctrl.flush <= 1'b0;
			dropClear  <= 1'b0;
			if (wrCommit)
			begin
				case (awAddr)
					`FS_REG_CTRL:
					begin
						ctrl.wrEnable <= wData[0];
						ctrl.flush    <= wData[1];
					end
					`FS_REG_WMARK: ctrl.watermark <= wData[`FS_PTR_WIDTH-1:0];
					// any value clears the count
					`FS_REG_DROP:  dropClear <= 1'b1;
					default:       ;
				endcase
			end
		end
	end

	//----------------------------------------
	// read machine
	//----------------------------------------
	// read decode, flush bit reads back 0
	always_comb
	begin
		rdWord = '0;
		case (axiReq.araddr)
			`FS_REG_CTRL:  rdWord = `FS_AXI_DW'({1'b0, ctrl.wrEnable});
			`FS_REG_WMARK: rdWord = `FS_AXI_DW'(ctrl.watermark);
			`FS_REG_STATUS:
			begin
				rdWord[0]                   = status.empty;
				rdWord[1]                   = status.full;
				rdWord[2]                   = mon.almostFull;
				rdWord[16 +: `FS_PTR_WIDTH] = status.level;
			end
			`FS_REG_DROP:  rdWord = `FS_AXI_DW'(mon.dropCount);
			// unmapped offsets read as zero
			default:       rdWord = '0;
		endcase
	end

	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
			rdState <= fifoStreamPkg::CSR_IDLE;
		else if (arAccept)
			rdState <= fifoStreamPkg::CSR_RESP;
		else if (axiRsp.rvalid && axiReq.rready)
			rdState <= fifoStreamPkg::CSR_IDLE;
	end

	// data captured with the address, held until rready
	always_ff @(posedge iCLK)
	begin
		if (arAccept)
			rData <= rdWord;
	end

endmodule

//--- source/FifoLevelMonitor.sv
`timescale 1ns/1ps

module FifoLevelMonitor
(
	input  logic                      iCLK,
	input  logic                      inARST,
	input  fifoStreamPkg::fsStatus_t  status,
	input  fifoStreamPkg::fsCtrl_t    ctrl,
	// raw producer valid and fifo ready
	input  logic                      wrValid,
	input  logic                      wrReady,
	// clear strobe from the csr
	input  logic                      dropClear,
	output fifoStreamPkg::fsMonitor_t mon
);

	logic dropEvent;
	logic countMax;

	// attempt while the fifo refuses, full or disabled alike
	assign dropEvent = wrValid && !wrReady;
	// counter holds at all ones
	assign countMax  = &mon.dropCount;

	//----------------------------------------
	// almost full
	//----------------------------------------
	// registered compare, one cycle behind the level
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
			mon.almostFull <= 1'b0;
		else
			mon.almostFull <= (status.level >= ctrl.watermark);
	end

	//----------------------------------------
	// rejected write counter
	//----------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			mon.dropCount <= '0;
		end
		else if (dropClear)
		begin
			// clear wins over a drop in the same cycle
			mon.dropCount <= '0;
		end
		else if (dropEvent && !countMax)
		begin
			mon.dropCount <= mon.dropCount + 1'b1;
		end
	end

endmodule

//--- source/FifoStreamTop.sv
`timescale 1ns/1ps

module FifoStreamTop
(
	input  logic                       iCLK,
	input  logic                       inARST,
	// axi4-lite slave
	input  fifoStreamPkg::axiLiteReq_t axiReq,
	output fifoStreamPkg::axiLiteRsp_t axiRsp,
	// write stream
	input  fifoStreamPkg::fsData_t     wrData,
	input  logic                       wrValid,
	output logic                       wrReady,
	// pop side
	input  logic                       rdReq,
	output fifoStreamPkg::fsData_t     rdData,
	output logic                       rdValid,
	output logic                       empty,
	// producer hint
	output logic                       almostFull
);

	fifoStreamPkg::fsCtrl_t    ctrl;
	fifoStreamPkg::fsStatus_t  status;
	fifoStreamPkg::fsMonitor_t mon;
	logic                      dropClear;

	//----------------------------------------
	// fifo core
	//----------------------------------------
	SyncFifoController i_SyncFifoController (
		.iCLK(iCLK),
		.inARST(inARST),
		.wrData(wrData),
		.wrValid(wrValid),
		.wrReady(wrReady),
		.rdReq(rdReq),
		.rdData(rdData),
		.rdValid(rdValid),
		.ctrl(ctrl),
		.status(status)
	);

	// watermark and drop counting
	FifoLevelMonitor i_FifoLevelMonitor (
		.iCLK(iCLK),
		.inARST(inARST),
		.status(status),
		.ctrl(ctrl),
		.wrValid(wrValid),
		.wrReady(wrReady),
		.dropClear(dropClear),
		.mon(mon)
	);

	//----------------------------------------
	// control and status registers
	//----------------------------------------
	FifoCsr i_FifoCsr (
		.iCLK(iCLK),
		.inARST(inARST),
		.axiReq(axiReq),
		.status(status),
		.mon(mon),
		.axiRsp(axiRsp),
		.ctrl(ctrl),
		.dropClear(dropClear)
	);

	assign empty      = status.empty;
	assign almostFull = mon.almostFull;

endmodule

//--- source/SdpBram.sv
`timescale 1ns/1ps

module SdpBram #(
	parameter int pDataWidth = 8,
	parameter int pAddrWidth = 9
)
(
	input  logic                  iCLK,
	// write side
	input  logic [pDataWidth-1:0] wrData,
	input  logic [pAddrWidth-1:0] wrAddr,
	input  logic                  wrEn,
	// read side
	input  logic [pAddrWidth-1:0] rdAddr,
	input  logic                  rdEn,
	output logic [pDataWidth-1:0] rdData
);

	localparam int lpEntries = 1 << pAddrWidth;

	// storage array, maps onto one block ram
	logic [pDataWidth-1:0] mem [lpEntries];

	//----------------------------------------
	// write port
	//----------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	//----------------------------------------
	// read port
	//----------------------------------------
	// output register loads only on rdEn
	always_ff @(posedge iCLK)
	begin
		if (rdEn)
			rdData <= mem[rdAddr];
	end

endmodule

//--- source/SyncFifoController.sv
`timescale 1ns/1ps
`include "fifoStream_config.svh"

module SyncFifoController
(
	input  logic                     iCLK,
	input  logic                     inARST,
	// write stream
	input  fifoStreamPkg::fsData_t   wrData,
	input  logic                     wrValid,
	output logic                     wrReady,
	// pop side
	input  logic                     rdReq,
	output fifoStreamPkg::fsData_t   rdData,
	output logic                     rdValid,
	// csr link
	input  fifoStreamPkg::fsCtrl_t   ctrl,
	output fifoStreamPkg::fsStatus_t status
);

	// slice geometry from the depth
	localparam int lpSliceWidth = fifoStreamPkg::fSliceWidth(`FS_DEPTH);
	localparam int lpSliceCount = fifoStreamPkg::fSliceCount(`FS_WIDTH, lpSliceWidth);
	// the slices together may be wider than a word
	localparam int lpPadWidth   = lpSliceWidth * lpSliceCount;

	fifoStreamPkg::fsPtr_t wrPtr;
	fifoStreamPkg::fsPtr_t rdPtr;
	fifoStreamPkg::fsPtr_t wrPtrNext;
	logic                  full;
	logic                  empty;
	logic                  wrAccept;
	logic                  rdAccept;
	logic [lpPadWidth-1:0] wrPad;
	logic [lpPadWidth-1:0] rdPad;

	//----------------------------------------
	// flags and handshakes
	//----------------------------------------
	assign wrPtrNext = wrPtr + 1'b1;
	// full one slot early, so equal pointers always mean empty
	assign full      = (wrPtrNext == rdPtr);
	assign empty     = (wrPtr == rdPtr);
	// writes gated by the csr enable
	assign wrReady   = ctrl.wrEnable && !full;
	assign wrAccept  = wrValid && wrReady;
	// a flush in the same cycle wins over a pop
	assign rdAccept  = rdReq && !empty && !ctrl.flush;

	//----------------------------------------
	// pointers
	//----------------------------------------
	always_ff @(posedge iCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			rdValid <= 1'b0;
		end
		else
		begin
			if (wrAccept)
				wrPtr <= wrPtrNext;
			// flush drops what is held, a write in the same cycle survives
			if (ctrl.flush)
				rdPtr <= wrPtr;
			else if (rdAccept)
				rdPtr <= rdPtr + 1'b1;
			// valid lines up with the bram output register
			rdValid <= rdAccept;
		end
	end

	// level wraps with the pointers
	assign status.level = wrPtr - rdPtr;
	assign status.full  = full;
	assign status.empty = empty;

	//----------------------------------------
	// bram slices
	//----------------------------------------
	// zero pad the word up to whole slices
	assign wrPad = lpPadWidth'(wrData);

	for (genvar s = 0; s < lpSliceCount; s++)
	begin : gSlice
		SdpBram #(
			.pDataWidth(lpSliceWidth),
			.pAddrWidth(`FS_PTR_WIDTH)
		) i_SdpBram (
			.iCLK(iCLK),
			.wrData(wrPad[s*lpSliceWidth +: lpSliceWidth]),
			.wrAddr(wrPtr),
			.wrEn(wrAccept),
			.rdAddr(rdPtr),
			.rdEn(rdAccept),
			.rdData(rdPad[s*lpSliceWidth +: lpSliceWidth])
		);
	end

	// pad bits dropped again
	assign rdData = rdPad[`FS_WIDTH-1:0];

endmodule

//--- source/fifoStreamPkg.sv
`include "fifoStream_config.svh"

package fifoStreamPkg;

	//----------------------------------------
	// vector types
	//----------------------------------------
	// one stream word
	typedef logic [`FS_WIDTH-1:0] fsData_t;
	// ram address and fifo pointer
	typedef logic [`FS_PTR_WIDTH-1:0] fsPtr_t;
	// fill level, max is depth minus one
	typedef logic [`FS_PTR_WIDTH-1:0] fsLevel_t;
	// rejected writes, saturating
	typedef logic [15:0] fsCount_t;
	typedef logic [`FS_AXI_AW-1:0] axiAddr_t;
	typedef logic [`FS_AXI_DW-1:0] axiData_t;

	//----------------------------------------
	// bundles between blocks
	//----------------------------------------
	// csr to fifo and monitor, flush is a single cycle pulse
	typedef struct packed
	{
		logic     wrEnable;
		logic     flush;
		fsLevel_t watermark;
	} fsCtrl_t;

	// fifo flags
	typedef struct packed
	{
		fsLevel_t level;
		logic     full;
		logic     empty;
	} fsStatus_t;

	typedef struct packed
	{
		logic     almostFull;
		fsCount_t dropCount;
	} fsMonitor_t;

	// master to slave channels
	typedef struct packed
	{
		logic     awvalid;
		axiAddr_t awaddr;
		logic     wvalid;
		axiData_t wdata;
		logic     bready;
		logic     arvalid;
		axiAddr_t araddr;
		logic     rready;
	} axiLiteReq_t;

	// slave to master channels
	typedef struct packed
	{
		logic     awready;
		logic     wready;
		logic     bvalid;
		logic     arready;
		logic     rvalid;
		axiData_t rdata;
	} axiLiteRsp_t;

	// shared by the csr write and read machines
	typedef enum logic
	{
		CSR_IDLE,
		CSR_RESP
	} csrState_t;

	//----------------------------------------
	// bram slicing
	//----------------------------------------
	// slice width from the bram depth
	function automatic int fSliceWidth(input int depth);
		case (depth)
			256:     return 16;
			512:     return 8;
			1024:    return 4;
			2048:    return 2;
			4096:    return 1;
			// unknown depth, fall back to single bit slices
			default: return 1;
		endcase
	endfunction

	// slices needed for one word, rounded up
	function automatic int fSliceCount(input int width, input int sliceWidth);
		return (width + sliceWidth - 1) / sliceWidth;
	endfunction

endpackage

//--- source/fifoStream_config.svh
`ifndef FIFOSTREAM_CONFIG_SVH
`define FIFOSTREAM_CONFIG_SVH

//----------------------------------------
// fifo geometry
//----------------------------------------
// storage entries, one of them always stays free
`define FS_DEPTH        512
// stream word width
`define FS_WIDTH        16
// log2 of the depth, pointers wrap on their own
`define FS_PTR_WIDTH    9

//----------------------------------------
// axi4-lite slave
//----------------------------------------
`define FS_AXI_AW       4
`define FS_AXI_DW       32

// register map, word aligned byte offsets
`define FS_REG_CTRL     4'h0
`define FS_REG_WMARK    4'h4
`define FS_REG_STATUS   4'h8
`define FS_REG_DROP     4'hC

`endif

//--- testbench/FifoStreamTb.sv
`timescale 1ns/1ps
`include "fifoStream_config.svh"

module FifoStreamTb;

	// one slot always stays free
	localparam int lpCapacity = `FS_DEPTH - 1;
	localparam int lpRows     = 36;

	typedef enum logic [2:0]
	{
		OP_WRITE,
		OP_READ,
		OP_MIXED,
		OP_AXI_WR,
		OP_AXI_RD,
		OP_STATUS,
		OP_DROP
	} opKind_t;

	// count is stream cycles, value is axi data or expected readback
	typedef struct packed
	{
		opKind_t                 op;
		fifoStreamPkg::axiAddr_t addr;
		logic [15:0]             count;
		fifoStreamPkg::axiData_t value;
	} stimRow_t;

	logic                       iCLK;
	logic                       inARST;
	fifoStreamPkg::axiLiteReq_t axiReq;
	fifoStreamPkg::axiLiteRsp_t axiRsp;
	fifoStreamPkg::fsData_t     wrData;
	logic                       wrValid;
	logic                       wrReady;
	logic                       rdReq;
	fifoStreamPkg::fsData_t     rdData;
	logic                       rdValid;
	logic                       empty;
	logic                       almostFull;

	//----------------------------------------
	// reference model state
	//----------------------------------------
	fifoStreamPkg::fsData_t model [$];
	int                     dropModel = 0;
	int                     wmModel   = `FS_DEPTH - 1 - 16;
	logic                   enModel   = 1'b1;
	// level seen by the registered almost full compare
	int                     prevSize  = 0;
	// pop expected on the next falling edge
	logic                   expValid  = 1'b0;
	fifoStreamPkg::fsData_t expData   = '0;
	logic [31:0]            rngState  = 32'h2f97f647;

	stimRow_t rows [lpRows] = '{
		// reset values and an unmapped offset
		'{OP_AXI_RD, `FS_REG_CTRL,   16'd0,   32'd1},
		'{OP_AXI_RD, `FS_REG_WMARK,  16'd0,   32'd495},
		'{OP_AXI_RD, `FS_REG_STATUS, 16'd0,   32'h0000_0001},
		'{OP_AXI_RD, 4'h2,           16'd0,   32'h0},
		// order and latency, then drain and pop on empty
		'{OP_MIXED,  4'h0,           16'd400, 32'h0},
		'{OP_READ,   4'h0,           16'd400, 32'h0},
		'{OP_READ,   4'h0,           16'd8,   32'h0},
		'{OP_STATUS, 4'h0,           16'd0,   32'h0},
		// fill up, then refused attempts
		'{OP_WRITE,  4'h0,           16'd511, 32'h0},
		'{OP_WRITE,  4'h0,           16'd20,  32'h0},
		'{OP_AXI_RD, `FS_REG_STATUS, 16'd0,   32'h01FF_0006},
		'{OP_DROP,   4'h0,           16'd0,   32'h0},
		'{OP_AXI_WR, `FS_REG_DROP,   16'd0,   32'h0000_5A5A},
		'{OP_AXI_RD, `FS_REG_DROP,   16'd0,   32'h0},
		'{OP_READ,   4'h0,           16'd511, 32'h0},
		// low watermark
		'{OP_AXI_WR, `FS_REG_WMARK,  16'd0,   32'd10},
		'{OP_AXI_RD, `FS_REG_WMARK,  16'd0,   32'd10},
		'{OP_WRITE,  4'h0,           16'd9,   32'h0},
		'{OP_STATUS, 4'h0,           16'd0,   32'h0},
		'{OP_WRITE,  4'h0,           16'd1,   32'h0},
		'{OP_AXI_RD, `FS_REG_STATUS, 16'd0,   32'h000A_0004},
		'{OP_READ,   4'h0,           16'd10,  32'h0},
		// write enable off and on
		'{OP_AXI_WR, `FS_REG_CTRL,   16'd0,   32'h0},
		'{OP_WRITE,  4'h0,           16'd5,   32'h0},
		'{OP_DROP,   4'h0,           16'd0,   32'h0},
		'{OP_AXI_WR, `FS_REG_CTRL,   16'd0,   32'h1},
		'{OP_WRITE,  4'h0,           16'd5,   32'h0},
		'{OP_STATUS, 4'h0,           16'd0,   32'h0},
		'{OP_READ,   4'h0,           16'd5,   32'h0},
		// flush with data held
		'{OP_WRITE,  4'h0,           16'd30,  32'h0},
		'{OP_AXI_WR, `FS_REG_CTRL,   16'd0,   32'h3},
		'{OP_STATUS, 4'h0,           16'd0,   32'h0},
		'{OP_AXI_RD, `FS_REG_CTRL,   16'd0,   32'd1},
		'{OP_MIXED,  4'h0,           16'd100, 32'h0},
		'{OP_READ,   4'h0,           16'd100, 32'h0},
		'{OP_STATUS, 4'h0,           16'd0,   32'h0}
	};

	FifoStreamTop i_FifoStreamTop (
		.iCLK(iCLK),
		.inARST(inARST),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.wrData(wrData),
		.wrValid(wrValid),
		.wrReady(wrReady),
		.rdReq(rdReq),
		.rdData(rdData),
		.rdValid(rdValid),
		.empty(empty),
		.almostFull(almostFull)
	);

	// 40 ns period
	initial
	begin
		iCLK = 1'b0;
		forever
			#20 iCLK = ~iCLK;
	end

	//----------------------------------------
	// failure reporting
	//----------------------------------------
	task automatic abortRun(input string reason);
		$display("** FAIL **");
		$fatal(1, "%s", reason);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
		abortRun({name, " does not match the model"});
	endtask

	// xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// STATUS word as the register map lays it out
	function automatic logic [31:0] statusWord();
		logic [31:0] w;
		int          lvl;
		lvl = model.size();
		w = '0;
		w[0] = (lvl == 0);
		w[1] = (lvl == lpCapacity);
		w[2] = (lvl >= wmModel);
		w[16 +: `FS_PTR_WIDTH] = fifoStreamPkg::fsLevel_t'(lvl);
		return w;
	endfunction

	//----------------------------------------
	// per cycle checks
	//----------------------------------------
	// pop data lands one cycle after the accepting edge
	task automatic checkRead();
		assert (rdValid === expValid)
		else reportMismatch("rdValid", 32'(rdValid), 32'(expValid));
		if (expValid)
			assert (rdData === expData)
			else reportMismatch("rdData", 32'(rdData), 32'(expData));
	endtask

	task automatic checkFlags();
		logic expReady;
		expReady = enModel && (model.size() < lpCapacity);
		assert (wrReady === expReady)
		else reportMismatch("wrReady", 32'(wrReady), 32'(expReady));
		assert (empty === (model.size() == 0))
		else reportMismatch("empty", 32'(empty), 32'(model.size() == 0));
		// compare runs one cycle behind the level
		assert (almostFull === (prevSize >= wmModel))
		else reportMismatch("almostFull", 32'(almostFull), 32'(prevSize >= wmModel));
		prevSize = model.size();
	endtask

	task automatic idleCycle();
		@(negedge iCLK);
		checkRead();
		expValid = 1'b0;
		wrValid  = 1'b0;
		rdReq    = 1'b0;
		prevSize = model.size();
	endtask

	// one stream cycle, model updated for the coming edge
	task automatic streamCycle(input logic doWrite, input logic doRead);
		fifoStreamPkg::fsData_t word;
		logic                   wrOk;
		logic                   rdOk;
		@(negedge iCLK);
		checkRead();
		checkFlags();
		wrOk = doWrite && enModel && (model.size() < lpCapacity);
		rdOk = doRead && (model.size() > 0);
		word = fifoStreamPkg::fsData_t'(nextRandom());
		// pop before push, flags come from the old pointers
		expValid = rdOk;
		if (rdOk)
			expData = model.pop_front();
		if (wrOk)
			model.push_back(word);
		else if (doWrite)
			dropModel++;
		wrData  = word;
		wrValid = doWrite;
		rdReq   = doRead;
	endtask

	//----------------------------------------
	// axi4-lite master
	//----------------------------------------
	task automatic axiWrite(input fifoStreamPkg::axiAddr_t addr,
		input fifoStreamPkg::axiData_t value);
		int waitCount;
		idleCycle();
		assert (axiRsp.awready && axiRsp.wready)
		else abortRun("CSR write channels not ready while idle");
		axiReq.awvalid = 1'b1;
		axiReq.awaddr  = addr;
		axiReq.wvalid  = 1'b1;
		axiReq.wdata   = value;
		axiReq.bready  = 1'b0;
		idleCycle();
		axiReq.awvalid = 1'b0;
		axiReq.wvalid  = 1'b0;
		waitCount = 0;
		while (!axiRsp.bvalid)
		begin
			idleCycle();
			waitCount++;
			if (waitCount > 16)
				abortRun("no write response from the CSR within 16 cycles");
		end
		// response held off one cycle, it has to stay up
		idleCycle();
		assert (axiRsp.bvalid === 1'b1)
		else reportMismatch("bvalid", 32'(axiRsp.bvalid), 32'd1);
		axiReq.bready = 1'b1;
		// handshake at this edge ends the response
		idleCycle();
		axiReq.bready = 1'b0;
		assert (!axiRsp.bvalid)
		else reportMismatch("bvalid", 32'(axiRsp.bvalid), 32'd0);
		case (addr)
			`FS_REG_CTRL:
			begin
				enModel = value[0];
				if (value[1])
					model.delete();
			end
			`FS_REG_WMARK: wmModel = int'(value[`FS_PTR_WIDTH-1:0]);
			`FS_REG_DROP:  dropModel = 0;
			default:       ;
		endcase
		prevSize = model.size();
	endtask

	task automatic axiRead(input fifoStreamPkg::axiAddr_t addr,
		output fifoStreamPkg::axiData_t data);
		int waitCount;
		// two quiet cycles so almost full has caught up
		idleCycle();
		idleCycle();
		assert (axiRsp.arready)
		else abortRun("CSR read address channel not ready while idle");
		axiReq.arvalid = 1'b1;
		axiReq.araddr  = addr;
		axiReq.rready  = 1'b0;
		idleCycle();
		axiReq.arvalid = 1'b0;
		waitCount = 0;
		while (!axiRsp.rvalid)
		begin
			idleCycle();
			waitCount++;
			if (waitCount > 16)
				abortRun("no read data from the CSR within 16 cycles");
		end
		data = axiRsp.rdata;
		// data held off one cycle, valid and value have to stay
		idleCycle();
		assert (axiRsp.rvalid === 1'b1)
		else reportMismatch("rvalid", 32'(axiRsp.rvalid), 32'd1);
		assert (axiRsp.rdata === data)
		else reportMismatch("rdata", axiRsp.rdata, data);
		axiReq.rready = 1'b1;
		idleCycle();
		axiReq.rready = 1'b0;
		assert (!axiRsp.rvalid)
		else reportMismatch("rvalid", 32'(axiRsp.rvalid), 32'd0);
	endtask

	//----------------------------------------
	// table rows
	//----------------------------------------
	task automatic applyRow(input stimRow_t row);
		fifoStreamPkg::axiData_t got;
		logic [31:0]             r;
		case (row.op)
			OP_WRITE:
				repeat (row.count)
					streamCycle(1'b1, 1'b0);
			OP_READ:
				repeat (row.count)
					streamCycle(1'b0, 1'b1);
			OP_MIXED:
				repeat (row.count)
				begin
					r = nextRandom();
					// writes three times in four, fill drifts upward
					streamCycle(r[0] | r[1], r[2]);
				end
			OP_AXI_WR:
				axiWrite(row.addr, row.value);
			OP_AXI_RD:
			begin
				axiRead(row.addr, got);
				assert (got === row.value)
				else reportMismatch("rdata", got, row.value);
			end
			OP_STATUS:
			begin
				axiRead(`FS_REG_STATUS, got);
				assert (got === statusWord())
				else reportMismatch("STATUS", got, statusWord());
			end
			OP_DROP:
			begin
				axiRead(`FS_REG_DROP, got);
				assert (got === 32'(dropModel))
				else reportMismatch("DROP", got, 32'(dropModel));
			end
			default:
				abortRun("unknown operation in the stimulus table");
		endcase
	endtask

	task automatic checkResetValues();
		assert (rdValid === 1'b0)
		else reportMismatch("rdValid", 32'(rdValid), 32'd0);
		assert (empty === 1'b1)
		else reportMismatch("empty", 32'(empty), 32'd1);
		assert (wrReady === 1'b1)
		else reportMismatch("wrReady", 32'(wrReady), 32'd1);
		assert (almostFull === 1'b0)
		else reportMismatch("almostFull", 32'(almostFull), 32'd0);
		assert (axiRsp.bvalid === 1'b0)
		else reportMismatch("bvalid", 32'(axiRsp.bvalid), 32'd0);
		assert (axiRsp.rvalid === 1'b0)
		else reportMismatch("rvalid", 32'(axiRsp.rvalid), 32'd0);
	endtask

	initial
	begin
		axiReq  = '0;
		wrData  = '0;
		wrValid = 1'b0;
		rdReq   = 1'b0;
		inARST  = 1'b0;
		// reset over two cycles, released on a falling edge
		repeat (2) @(posedge iCLK);
		@(negedge iCLK);
		inARST = 1'b1;
		checkResetValues();
		foreach (rows[i])
			applyRow(rows[i]);
		// let the last pop land
		idleCycle();
		idleCycle();
		$display("** PASS **");
		$finish;
	end

	//----------------------------------------
	// watchdog
	//----------------------------------------
	// four cycles per counted step, plus room for each axi row
	initial
	begin
		int budget;
		budget = 0;
		foreach (rows[i])
			budget += int'(rows[i].count);
		budget = budget * 4 + lpRows * 20 + 100;
		repeat (budget) @(posedge iCLK);
		abortRun("simulation ran past its cycle budget, the DUT appears stuck");
	end

endmodule

//--- testbench/FifoStream_sva.sv
`timescale 1ns/1ps

module FifoStreamSva
(
	input logic                       iCLK,
	input logic                       inARST,
	input logic                       empty,
	input logic                       rdValid,
	input logic                       wrReady,
	input fifoStreamPkg::fsStatus_t   status,
	input fifoStreamPkg::axiLiteReq_t axiReq,
	input fifoStreamPkg::axiLiteRsp_t axiRsp
);

	//----------------------------------------
	// stream side
	//----------------------------------------
	// an empty cycle never yields pop data
	aNoPopFromEmpty: assert property (
		@(posedge iCLK) disable iff (!inARST)
		empty |=> !rdValid
	) else $error("rdValid followed a cycle with the FIFO empty");

	// producer held off while full
	aNoReadyWhenFull: assert property (
		@(posedge iCLK) disable iff (!inARST)
		status.full |-> !wrReady
	) else $error("wrReady high while the FIFO is full");

	//----------------------------------------
	// axi4-lite responses
	//----------------------------------------
	aBvalidHold: assert property (
		@(posedge iCLK) disable iff (!inARST)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid
	) else $error("bvalid dropped before bready");

	aRvalidHold: assert property (
		@(posedge iCLK) disable iff (!inARST)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid
	) else $error("rvalid dropped before rready");

endmodule

// checker rides along inside every top instance
bind FifoStreamTop FifoStreamSva i_FifoStreamSva (
	.iCLK(iCLK),
	.inARST(inARST),
	.empty(empty),
	.rdValid(rdValid),
	.wrReady(wrReady),
	.status(status),
	.axiReq(axiReq),
	.axiRsp(axiRsp)
);
